// File: include/singleBusCpu_config.svh
// Machine widths, memory depth and IR field positions, included by the packages and RTL.
`ifndef SINGLE_BUS_CPU_CONFIG_SVH
`define SINGLE_BUS_CPU_CONFIG_SVH

`define SBC_WORD_WIDTH 32
`define SBC_REG_COUNT  16
`define SBC_MEM_DEPTH  512

// top bit of each 4-bit register field in IR.
`define SBC_RA_MSB 26
`define SBC_RB_MSB 22
`define SBC_RC_MSB 18

`define SBC_IMM_WIDTH 19 // constant field sits in the low bits of IR.

`endif

// File: singleBusCpu.f
+incdir+include
src/isaPkg.sv
src/datapathPkg.sv
src/registerFile.sv
src/selectEncode.sv
src/arithUnit.sv
src/memoryInterface.sv
src/busDatapath.sv
test/singleBusCpu_asserts.sv
test/singleBusCpu_tb.sv

// File: src/arithUnit.sv
// Combinational operation unit computing Y op bus into a 64-bit result for the Z pair.
`include "singleBusCpu_config.svh"

module arithUnit (
	input  datapathPkg::word       yValue,
	input  datapathPkg::word       busValue,
	input  isaPkg::aluOp           op,
	output datapathPkg::doubleWord result
);

	localparam int Width = `SBC_WORD_WIDTH;

	logic [4:0] shiftAmount;
	datapathPkg::doubleWord yTwice;
	datapathPkg::doubleWord rotRight;
	datapathPkg::doubleWord rotLeft;
	datapathPkg::doubleWord product;

	assign shiftAmount = busValue[4:0]; // counts above 31 wrap.

	// rotates come from shifting two copies of Y side by side.
	assign yTwice = {yValue, yValue};
	assign rotRight = yTwice >> shiftAmount;
	assign rotLeft = yTwice << shiftAmount;

	// the low 64 bits of the sign-extended product give the signed result.
	assign product = {{Width{yValue[Width-1]}}, yValue} *
		{{Width{busValue[Width-1]}}, busValue};

	// ============================================================
	// operation select
	// ============================================================

	always_comb begin
		result = '0;
		case (op)
			isaPkg::opAdd:
				result[Width-1:0] = yValue + busValue;
			isaPkg::opSub:
				result[Width-1:0] = yValue - busValue;
			isaPkg::opAnd:
				result[Width-1:0] = yValue & busValue;
			isaPkg::opOr:
				result[Width-1:0] = yValue | busValue;
			isaPkg::opShr:
				result[Width-1:0] = yValue >> shiftAmount;
			isaPkg::opShra:
				result[Width-1:0] = $signed(yValue) >>> shiftAmount;
			isaPkg::opShl:
				result[Width-1:0] = yValue << shiftAmount;
			isaPkg::opRor:
				result[Width-1:0] = rotRight[Width-1:0];
			isaPkg::opRol:
				result[Width-1:0] = rotLeft[2*Width-1:Width];
			isaPkg::opNeg:
				result[Width-1:0] = -busValue; // unary operations act on the bus alone.
			isaPkg::opNot:
				result[Width-1:0] = ~busValue;
			isaPkg::opMul:
				result = product;
			isaPkg::opIncPc:
				result[Width-1:0] = busValue + 1'b1;
			default:
				result = '0;
		endcase
	end

endmodule

// File: src/busDatapath.sv
// Top of the single-bus datapath, driven one control step per clock by an external controller.
`include "singleBusCpu_config.svh"

module busDatapath (
	input  logic                 Clock,
	input  logic                 arstN,
	input  datapathPkg::ctrlStep ctrl,
	input  datapathPkg::word     mDataIn,
	output datapathPkg::word     busValue
);

	datapathPkg::word pc;
	datapathPkg::word ir;
	datapathPkg::word y;
	datapathPkg::doubleWord z;
	datapathPkg::word hi;
	datapathPkg::word lo;

	datapathPkg::regEnables regLoadEn;
	datapathPkg::regEnables regOutEn;
	datapathPkg::word regValue;
	datapathPkg::word constant;
	datapathPkg::word mdrValue;
	datapathPkg::doubleWord aluResult;
	isaPkg::aluOp aluOpSel;

	// ============================================================
	// special registers
	// ============================================================

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			ir <= '0;
			y  <= '0;
			z  <= '0;
			hi <= '0;
			lo <= '0;
		end else begin
			if (ctrl.pcIn) pc <= busValue;
			if (ctrl.irIn) ir <= busValue;
			if (ctrl.yIn) y <= busValue;
			if (ctrl.zIn) z <= aluResult; // both halves load together.
			if (ctrl.hiIn) hi <= busValue;
			if (ctrl.loIn) lo <= busValue;
		end
	end

	// ============================================================
	// bus multiplexer
	// ============================================================

	always_comb begin
		busValue = '0;
		if (ctrl.rOut || ctrl.baOut) begin
			busValue = regValue;
		end else if (ctrl.pcOut) begin
			busValue = pc;
		end else if (ctrl.zHighOut) begin
			busValue = z[2*`SBC_WORD_WIDTH-1:`SBC_WORD_WIDTH];
		end else if (ctrl.zLowOut) begin
			busValue = z[`SBC_WORD_WIDTH-1:0];
		end else if (ctrl.hiOut) begin
			busValue = hi;
		end else if (ctrl.loOut) begin
			busValue = lo;
		end else if (ctrl.mdrOut) begin
			busValue = mdrValue;
		end else if (ctrl.cOut) begin
			busValue = constant;
		end else if (ctrl.inPortOut) begin
			busValue = mDataIn;
		end
	end

	// the fetch step raises incPc alongside whatever operation field it carries.
	assign aluOpSel = ctrl.incPc ? isaPkg::opIncPc : ctrl.op;

	// ============================================================
	// blocks
	// ============================================================

	registerFile i_registerFile (
		.Clock(Clock), .arstN(arstN), .busValue(busValue), .loadEn(regLoadEn),
		.outEn(regOutEn), .baseAddr(ctrl.baOut), .regValue(regValue)
	);

	selectEncode i_selectEncode (
		.instr(ir), .gra(ctrl.gra), .grb(ctrl.grb), .grc(ctrl.grc), .rIn(ctrl.rIn),
		.rOut(ctrl.rOut), .baOut(ctrl.baOut), .loadEn(regLoadEn), .outEn(regOutEn),
		.constant(constant)
	);

	arithUnit i_arithUnit (
		.yValue(y), .busValue(busValue), .op(aluOpSel), .result(aluResult)
	);

	memoryInterface i_memoryInterface (
		.Clock(Clock), .arstN(arstN), .busValue(busValue), .marIn(ctrl.marIn),
		.mdrIn(ctrl.mdrIn), .read(ctrl.read), .write(ctrl.write), .mdrValue(mdrValue)
	);

endmodule

// File: src/datapathPkg.sv
// Datapath value types and the control step that the control unit drives each clock.
`include "singleBusCpu_config.svh"

package datapathPkg;

	typedef logic [`SBC_WORD_WIDTH-1:0] word;
	typedef logic [2*`SBC_WORD_WIDTH-1:0] doubleWord;
	typedef logic [`SBC_REG_COUNT-1:0] regEnables; // bit n belongs to register Rn.

	// ============================================================
	// one control step, most significant field first
	// ============================================================

	typedef struct packed {
		// bus sources, at most one is high in a step.
		logic pcOut;
		logic zHighOut;
		logic zLowOut;
		logic mdrOut;
		logic hiOut;
		logic loOut;
		logic cOut;
		logic inPortOut;
		// register loads at the rising edge.
		logic pcIn;
		logic irIn;
		logic yIn;
		logic zIn;
		logic hiIn;
		logic loIn;
		logic marIn;
		logic mdrIn;
		// general register selection through the IR fields.
		logic gra;
		logic grb;
		logic grc;
		logic rIn;
		logic rOut;
		logic baOut;
		// unit and memory controls.
		logic incPc;
		logic read;
		logic write;
		isaPkg::aluOp op;
	} ctrlStep;

endpackage

// File: src/isaPkg.sv
// Instruction-level types shared by the decoder, the operation unit and the control step.
`include "singleBusCpu_config.svh"

package isaPkg;

	// ============================================================
	// instruction fields
	// ============================================================

	typedef logic [$clog2(`SBC_REG_COUNT)-1:0] regIndex;
	typedef logic [`SBC_IMM_WIDTH-1:0] immField;

	// ============================================================
	// operations of the arithmetic unit
	// ============================================================

	typedef enum logic [3:0] {
		opNone  = 4'd0,
		opAdd   = 4'd1,
		opSub   = 4'd2,
		opAnd   = 4'd3,
		opOr    = 4'd4,
		opShr   = 4'd5,
		opShra  = 4'd6,
		opShl   = 4'd7,
		opRor   = 4'd8,
		opRol   = 4'd9,
		opNeg   = 4'd10,
		opNot   = 4'd11,
		opMul   = 4'd12,
		opIncPc = 4'd13 // bus plus one, used by the fetch step.
	} aluOp;

endpackage

// File: src/memoryInterface.sv
// MAR, MDR and the word memory, with reads and writes completing at the clock edge.
`include "singleBusCpu_config.svh"

module memoryInterface (
	input  logic             Clock,
	input  logic             arstN,
	input  datapathPkg::word busValue,
	input  logic             marIn,
	input  logic             mdrIn,
	input  logic             read,
	input  logic             write,
	output datapathPkg::word mdrValue
);

	localparam int AddrWidth = $clog2(`SBC_MEM_DEPTH);

	datapathPkg::word mar;
	datapathPkg::word mdr;
	datapathPkg::word memory [`SBC_MEM_DEPTH];
	logic [AddrWidth-1:0] address;
	datapathPkg::word memWord;

	assign address = mar[AddrWidth-1:0]; // upper MAR bits are ignored.
	assign memWord = memory[address];

	// ============================================================
	// address and data registers
	// ============================================================

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			mar <= '0;
			mdr <= '0;
		end else begin
			if (marIn) begin
				mar <= busValue;
			end
			// a memory read wins over the bus as the MDR source.
			if (read) begin
				mdr <= memWord;
			end else if (mdrIn) begin
				mdr <= busValue;
			end
		end
	end

	// ============================================================
	// word memory
	// ============================================================

	always_ff @(posedge Clock) begin
		if (write) begin
			memory[address] <= mdr;
		end
	end

	assign mdrValue = mdr;

endmodule

// File: src/registerFile.sv
// Sixteen general registers loaded from the bus, with R0 reading zero under base addressing.
`include "singleBusCpu_config.svh"

module registerFile (
	input  logic                   Clock,
	input  logic                   arstN,
	input  datapathPkg::word       busValue,
	input  datapathPkg::regEnables loadEn,
	input  datapathPkg::regEnables outEn,
	input  logic                   baseAddr,
	output datapathPkg::word       regValue
);

	datapathPkg::word regs [`SBC_REG_COUNT];

	// ============================================================
	// register storage
	// ============================================================

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `SBC_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `SBC_REG_COUNT; i++) begin
				if (loadEn[i]) begin
					regs[i] <= busValue;
				end
			end
		end
	end

	// ============================================================
	// read port
	// ============================================================

	// the enables are one-hot, so an OR of the gated registers is the selected one.
	always_comb begin
		regValue = '0;
		if (outEn[0] && !baseAddr) begin
			regValue = regs[0]; // R0 as a base register contributes zero.
		end
		for (int i = 1; i < `SBC_REG_COUNT; i++) begin
			if (outEn[i]) begin
				regValue = regValue | regs[i];
			end
		end
	end

endmodule

// File: src/selectEncode.sv
// Turns the IR register fields into register enables and sign-extends the constant field.
`include "singleBusCpu_config.svh"

module selectEncode (
	input  datapathPkg::word       instr,
	input  logic                   gra,
	input  logic                   grb,
	input  logic                   grc,
	input  logic                   rIn,
	input  logic                   rOut,
	input  logic                   baOut,
	output datapathPkg::regEnables loadEn,
	output datapathPkg::regEnables outEn,
	output datapathPkg::word       constant
);

	localparam int IndexWidth = $bits(isaPkg::regIndex);

	isaPkg::regIndex ra;
	isaPkg::regIndex rb;
	isaPkg::regIndex rc;
	isaPkg::regIndex selected;
	isaPkg::immField imm;
	logic anySelect;
	datapathPkg::regEnables decoded;

	assign ra = instr[`SBC_RA_MSB -: IndexWidth];
	assign rb = instr[`SBC_RB_MSB -: IndexWidth];
	assign rc = instr[`SBC_RC_MSB -: IndexWidth];
	assign imm = instr[`SBC_IMM_WIDTH-1:0];

	always_comb begin
		selected = '0;
		if (gra) begin
			selected = ra;
		end else if (grb) begin
			selected = rb;
		end else if (grc) begin
			selected = rc;
		end
	end

	assign anySelect = gra | grb | grc;
	assign decoded = anySelect ? (datapathPkg::regEnables'(1) << selected) : '0;

	assign loadEn = rIn ? decoded : '0;
	assign outEn = (rOut || baOut) ? decoded : '0; // base addressing reads the same field.

	assign constant = {{(`SBC_WORD_WIDTH-`SBC_IMM_WIDTH){imm[`SBC_IMM_WIDTH-1]}}, imm};

endmodule

// File: test/singleBusCpu_asserts.sv
// Concurrent checks on the control steps of the datapath, bound into busDatapath.
module singleBusCpuAsserts (
	input logic                 Clock,
	input logic                 arstN,
	input datapathPkg::ctrlStep ctrl,
	input datapathPkg::word     pc,
	input datapathPkg::word     mar
);

	logic [9:0] busSources;

	// general registers drive the bus through rOut or baOut.
	assign busSources = {ctrl.pcOut, ctrl.zHighOut, ctrl.zLowOut, ctrl.mdrOut, ctrl.hiOut,
		ctrl.loOut, ctrl.cOut, ctrl.inPortOut, ctrl.rOut, ctrl.baOut};

	singleSource: assert property (@(posedge Clock) disable iff (!arstN) $onehot0(busSources))
		else $error("more than one bus source is active in one step");

	noReadWrite: assert property (@(posedge Clock) disable iff (!arstN) !(ctrl.read && ctrl.write))
		else $error("read and write are high in the same step");

	// the first edge after release still sees the reset values.
	resetState: assert property (@(posedge Clock) $rose(arstN) |-> (pc == '0 && mar == '0))
		else $error("PC or MAR is not zero after reset");

endmodule

bind busDatapath singleBusCpuAsserts i_asserts (
	.Clock(Clock), .arstN(arstN), .ctrl(ctrl), .pc(pc), .mar(i_memoryInterface.mar)
);

// File: test/singleBusCpu_tb.sv
// Testbench that replays control steps from the data file into busDatapath and checks the bus.
module singleBusCpuTb;

	localparam int MaxLines = 64;

	logic Clock;
	logic arstN;
	datapathPkg::ctrlStep ctrl;
	datapathPkg::word mDataIn;
	datapathPkg::word busValue;

	logic [31:0] vectors [4*MaxLines]; // four columns per data line.
	int lineCount;
	int cycleLimit = 0;
	int cycles = 0;
	int errorCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	datapathPkg::word zHighSeen;
	datapathPkg::word zHighWanted;

	busDatapath i_dut (
		.Clock(Clock), .arstN(arstN), .ctrl(ctrl), .mDataIn(mDataIn), .busValue(busValue)
	);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("Timeout: the steps did not finish within %0d cycles.", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic compareWord(input string name, input datapathPkg::word expected,
		input datapathPkg::word actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic matchPair(input string name, input datapathPkg::doubleWord expected,
		input datapathPkg::doubleWord actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	// ============================================================
	// replay of the data file
	// ============================================================

	initial begin
		int base;
		int mark;
		logic [31:0] flag;
		ctrl = '0;
		mDataIn = '0;
		arstN = 1'b0;
		$readmemh("test/singleBusCpu_testdata.txt", vectors);
		lineCount = 0;
		while (lineCount < MaxLines && vectors[4*lineCount+3] !== 32'h9) begin
			lineCount++;
		end
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		arstN = 1'b1;
		if (lineCount == MaxLines) begin
			$display("The data file has no end line, so no step was run.");
			errorCount++;
		end else begin
			cycleLimit = 2*lineCount + 20;
			mark = errorCount;
			for (int n = 0; n < lineCount; n++) begin
				base = 4*n;
				flag = vectors[base+3];
				if (flag == 32'h8) begin
					if (errorCount == mark) begin
						$display("test %0d passed", vectors[base+2]);
						testsPassed++;
					end else begin
						$display("test %0d failed with %0d errors", vectors[base+2], errorCount - mark);
						testsFailed++;
					end
					mark = errorCount;
				end else begin
					@(negedge Clock);
					ctrl = datapathPkg::ctrlStep'(vectors[base][28:0]);
					mDataIn = vectors[base+1];
					#1; // bus settles well before the next rising edge.
					if (flag == 32'h1) begin
						compareWord("busValue", vectors[base+2], busValue);
					end else if (flag == 32'h2) begin
						zHighSeen = busValue;
						zHighWanted = vectors[base+2];
					end else if (flag == 32'h3) begin
						matchPair("Z", {zHighWanted, vectors[base+2]}, {zHighSeen, busValue});
					end
				end
			end
			@(negedge Clock);
			ctrl = '0;
			mDataIn = '0;
		end
		$display("%0d tests passed, %0d tests failed", testsPassed, testsFailed);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: test/singleBusCpu_testdata.txt
// columns: control step image, mDataIn word, expected bus word, check flag.
// flags: 0 drive only, 1 check bus, 2 hold Z high, 3 check Z pair, 8 end of test, 9 end of data.
10000000 00000000 00000000 1
04000000 00000000 00000000 1
02000000 00000000 00000000 1
00000000 00000000 00000001 8
// IR holds ra = 5 and rb = 0.
00280000 02800000 02800000 0
00202000 DEADBEEF DEADBEEF 0
02001200 00000000 DEADBEEF 1
00001100 00000000 DEADBEEF 1
00200A00 12345678 12345678 0
00000900 00000000 12345678 1
00000880 00000000 00000000 1
00000000 00000000 00000002 8
// each step reads the last Z low and feeds it to the next operation.
00240000 800000F1 800000F1 1
00220001 00000104 00000104 0
04020002 00000000 800001F5 1
04020003 00000000 FFFFFEFC 1
04020004 00000000 800000F0 1
0402000B 00000000 800000F1 1
04020006 00000000 7FFFFF0E 1
0402000B 00000000 FFFE0000 1
04020005 00000000 0001FFFF 1
04020007 00000000 00000001 1
04020008 00000000 000001E2 1
04020009 00000000 6000003C 1
0402000A 00000000 1800000F 1
04020040 00000000 E7FFFFF1 1
0402000C 00000000 E7FFFFF2 1
08000000 00000000 0BFFFFF0 2
04000000 00000000 67FFF2D2 3
00000000 00000000 00000003 8
00204000 00000010 00000010 0
00202000 CAFEF00D CAFEF00D 0
00204010 00000011 00000011 0
00202000 0BADF00D 0BADF00D 0
00204010 00000010 00000010 0
00000020 00000000 00000000 1
02000000 00000000 CAFEF00D 1
00000000 00000000 00000004 8
// load R2 from 0x7FF21(R5), which lands on word 0x10.
00204000 00000000 00000000 0
00202000 012FFF21 012FFF21 0
00000010 00000000 00000000 0
10024040 00000000 00000000 1
04102020 00000000 00000001 1
02080000 00000000 012FFF21 1
00040880 00000000 DEADBEEF 1
00420001 00000000 FFFFFF21 1
04004000 00000000 DEADBE10 1
00002020 00000000 00000000 0
02001200 00000000 CAFEF00D 1
00001100 00000000 CAFEF00D 1
00000000 00000000 00000005 8
00000000 00000000 00000000 9
